// File: hw/pipeline_defines.svh
`ifndef PIPELINE_DEFINES_SVH
`define PIPELINE_DEFINES_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

// Instruction word
`define INSTR_W 32
// Register index
`define REG_W 5
// Program counter
`define PC_W 32

////////////////////////////////////////////////////////////
// Fixed encodings
////////////////////////////////////////////////////////////

// Function field of JR under the R-type opcode
`define FUNCT_JR 6'h08
// Return address register for JAL
`define LINK_REG 5'd31

`endif

// File: hw/pipelinePkg.sv
package pipelinePkg;

    ////////////////////////////////////////////////////////////
    // Primary opcodes seen by the front end
    ////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        // Register format, function field selects the operation
        opRtype = 6'd0,
        // Jumps
        opJ     = 6'd2,
        opJal   = 6'd3,
        // Conditional branches
        opBeq   = 6'd4,
        opBne   = 6'd5,
        opBlez  = 6'd6,
        opBgtz  = 6'd7,
        // Immediate arithmetic and logic
        opAddi  = 6'd8,
        opAddiu = 6'd9,
        opSlti  = 6'd10,
        opAndi  = 6'd12,
        opOri   = 6'd13,
        opLui   = 6'd15,
        // Memory access
        opLw    = 6'd35,
        opSw    = 6'd43
    } opcodeE;

    ////////////////////////////////////////////////////////////
    // Hazard classification
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        stallNone    = 2'd0,
        stallData    = 2'd1,
        stallControl = 2'd2
    } stallKindE;

endpackage

// File: hw/pipeWriterIf.sv
`timescale 1ns/100ps
`include "pipeline_defines.svh"

interface pipeWriterIf;

    // EX stage writer
    logic              exRegWrite;
    logic [`REG_W-1:0] exRd;

    // MEM stage writer
    logic              memRegWrite;
    logic [`REG_W-1:0] memRd;

    // Tracker side owns the stage registers
    modport track (
        output exRegWrite, exRd,
        output memRegWrite, memRd
    );

    // Hazard side only compares
    modport detect (
        input exRegWrite, exRd,
        input memRegWrite, memRd
    );

endinterface

// File: hw/fetchUnit.sv
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module fetchUnit (
    input  logic                  clk,
    input  logic                  arstN,
    input  pipelinePkg::stallKindE stallKind,
    input  logic [`INSTR_W-1:0]   imemData,
    output logic [`PC_W-1:0]      imemAddr,
    output logic [`INSTR_W-1:0]   decodeInstr
);
    import pipelinePkg::*;

    ////////////////////////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////////////////////////

    logic [`PC_W-1:0] pc;
    // Any stall kind freezes the front end
    logic             advance;

    assign advance = (stallKind == stallNone);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (advance) begin
            // Sequential fetch only, branches never redirect here
            pc <= pc + `PC_W'd4;
        end
    end

    // Memory is addressed straight from the PC
    assign imemAddr = pc;

    ////////////////////////////////////////////////////////////
    // Fetch to decode register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            // All zero word decodes as a no-op
            decodeInstr <= '0;
        end else if (advance) begin
            decodeInstr <= imemData;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Fetch address frozen across the stalled edge
    pcHoldOnStall: assert property (
        @(posedge clk) disable iff (!arstN)
        (stallKind != stallNone) |=> $stable(imemAddr)
    ) else $error("fetchUnit: PC moved during a stall");

endmodule

// File: hw/destDecode.sv
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module destDecode (
    input  logic [`INSTR_W-1:0] decodeInstr,
    output logic                idRegWrite,
    output logic [`REG_W-1:0]   idRd
);
    import pipelinePkg::*;

    ////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////

    opcodeE            opcode;
    logic [5:0]        funct;
    logic [`REG_W-1:0] rtField;
    logic [`REG_W-1:0] rdField;

    assign opcode  = opcodeE'(decodeInstr[31:26]);
    assign funct   = decodeInstr[5:0];
    // I-type destination
    assign rtField = decodeInstr[20:16];
    // R-type destination
    assign rdField = decodeInstr[15:11];

    ////////////////////////////////////////////////////////////
    // Destination selection
    ////////////////////////////////////////////////////////////

    logic              rawWrite;
    logic [`REG_W-1:0] rawRd;

    always_comb begin
        rawWrite = 1'b0;
        rawRd    = '0;
        case (opcode)
            opRtype: begin
                // JR only reads rs
                if (funct != `FUNCT_JR) begin
                    rawWrite = 1'b1;
                    rawRd    = rdField;
                end
            end
            opAddi, opAddiu, opSlti, opAndi, opOri, opLui, opLw: begin
                rawWrite = 1'b1;
                rawRd    = rtField;
            end
            opJal: begin
                // Return address goes to the link register
                rawWrite = 1'b1;
                rawRd    = `LINK_REG;
            end
            default: begin
                // Branches, J, SW and unknown opcodes write nothing
                rawWrite = 1'b0;
                rawRd    = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Register zero filter
    ////////////////////////////////////////////////////////////

    // r0 is hardwired so writing it is not a hazard
    assign idRegWrite = rawWrite && (rawRd != '0);
    // Empty destination reads as zero downstream
    assign idRd       = idRegWrite ? rawRd : '0;

endmodule

// File: hw/writerTrack.sv
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module writerTrack (
    input  logic                   clk,
    input  logic                   arstN,
    input  pipelinePkg::stallKindE stallKind,
    input  logic                   idRegWrite,
    input  logic [`REG_W-1:0]      idRd,
    pipeWriterIf.track             writer
);
    import pipelinePkg::*;

    ////////////////////////////////////////////////////////////
    // Next EX contents
    ////////////////////////////////////////////////////////////

    logic              exLoadWrite;
    logic [`REG_W-1:0] exLoadRd;

    always_comb begin
        if (stallKind != stallNone) begin
            // Bubble while decode is held
            exLoadWrite = 1'b0;
            exLoadRd    = '0;
        end else begin
            exLoadWrite = idRegWrite;
            exLoadRd    = idRd;
        end
    end

    ////////////////////////////////////////////////////////////
    // EX and MEM stage registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            writer.exRegWrite  <= 1'b0;
            writer.exRd        <= '0;
            writer.memRegWrite <= 1'b0;
            writer.memRd       <= '0;
        end else begin
            writer.exRegWrite  <= exLoadWrite;
            writer.exRd        <= exLoadRd;
            // MEM always drains EX so a stall can resolve
            writer.memRegWrite <= writer.exRegWrite;
            writer.memRd       <= writer.exRd;
        end
    end

    // Empty slots carry no stale register index
    emptyStageZero: assert property (
        @(posedge clk) disable iff (!arstN)
        (writer.exRegWrite || (writer.exRd == '0)) &&
        (writer.memRegWrite || (writer.memRd == '0))
    ) else $error("writerTrack: empty stage holds a destination");

endmodule

// File: hw/hazardDetect.sv
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module hazardDetect (
    input  logic [`INSTR_W-1:0]     decodeInstr,
    pipeWriterIf.detect             writer,
    output pipelinePkg::stallKindE  stallKind
);
    import pipelinePkg::*;

    ////////////////////////////////////////////////////////////
    // Source operands of the decode instruction
    ////////////////////////////////////////////////////////////

    opcodeE            opcode;
    logic [5:0]        funct;
    logic [`REG_W-1:0] rs;
    logic [`REG_W-1:0] rt;

    assign opcode = opcodeE'(decodeInstr[31:26]);
    assign funct  = decodeInstr[5:0];
    assign rs     = decodeInstr[25:21];
    assign rt     = decodeInstr[20:16];

    ////////////////////////////////////////////////////////////
    // Writer matches
    ////////////////////////////////////////////////////////////

    logic exMatch;
    logic memMatch;
    logic anyMatch;

    // Tracker never flags a write to r0
    assign exMatch  = writer.exRegWrite  && ((writer.exRd  == rs) || (writer.exRd  == rt));
    assign memMatch = writer.memRegWrite && ((writer.memRd == rs) || (writer.memRd == rt));
    assign anyMatch = exMatch || memMatch;

    ////////////////////////////////////////////////////////////
    // Classification
    ////////////////////////////////////////////////////////////

    // Instructions that resolve control flow in decode
    logic isControl;

    always_comb begin
        case (opcode)
            opBeq, opBne, opBlez, opBgtz: isControl = 1'b1;
            opRtype:                      isControl = (funct == `FUNCT_JR);
            default:                      isControl = 1'b0;
        endcase
    end

    always_comb begin
        // Control rule has priority over the plain data rule
        if (!anyMatch) begin
            stallKind = stallNone;
        end else if (isControl) begin
            stallKind = stallControl;
        end else begin
            stallKind = stallData;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Raw opcode bits cross checked against the classification
    always_comb begin
        if (stallKind == stallControl) begin
            assert ((decodeInstr[31:28] == 4'b0001) ||
                    ((decodeInstr[31:26] == 6'd0) && (decodeInstr[5:0] == `FUNCT_JR)))
            else $error("hazardDetect: control stall without branch or JR");
        end
    end

endmodule

// File: hw/hazardUnit.sv
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module hazardUnit (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`INSTR_W-1:0]    imemData,
    output logic [`PC_W-1:0]       imemAddr,
    output logic [`INSTR_W-1:0]    decodeInstr,
    output pipelinePkg::stallKindE stallKind
);

    ////////////////////////////////////////////////////////////
    // Internal connections
    ////////////////////////////////////////////////////////////

    // Decode stage destination
    logic              idRegWrite;
    logic [`REG_W-1:0] idRd;

    // EX and MEM writers toward the detector
    pipeWriterIf writerBus ();

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////

    fetchUnit u_fetchUnit (
        .clk         (clk),
        .arstN       (arstN),
        .stallKind   (stallKind),
        .imemData    (imemData),
        .imemAddr    (imemAddr),
        .decodeInstr (decodeInstr)
    );

    destDecode u_destDecode (
        .decodeInstr (decodeInstr),
        .idRegWrite  (idRegWrite),
        .idRd        (idRd)
    );

    // Stage registers
    writerTrack u_writerTrack (
        .clk        (clk),
        .arstN      (arstN),
        .stallKind  (stallKind),
        .idRegWrite (idRegWrite),
        .idRd       (idRd),
        .writer     (writerBus.track)
    );

    // Combinational compare against decode sources
    hazardDetect u_hazardDetect (
        .decodeInstr (decodeInstr),
        .writer      (writerBus.detect),
        .stallKind   (stallKind)
    );

endmodule

// File: tests/tb_hazardUnit.sv
`timescale 1ns/100ps
`include "pipeline_defines.svh"

module tb_hazardUnit;
    import pipelinePkg::*;

    // Cycles any wait may take before it gives up
    localparam int waitLimit = 40;

    logic                clk;
    logic                arstN;
    logic [`INSTR_W-1:0] imemData;
    logic [`PC_W-1:0]    imemAddr;
    logic [`INSTR_W-1:0] decodeInstr;
    stallKindE           stallKind;

    // Instruction memory, one word per entry
    logic [`INSTR_W-1:0] prog [0:255];

    // Reference pipeline state
    logic [`PC_W-1:0]    refPc;
    logic [`INSTR_W-1:0] refInstr;
    logic                refExW;
    logic [`REG_W-1:0]   refExRd;
    logic                refMemW;
    logic [`REG_W-1:0]   refMemRd;

    // Last sampled DUT outputs
    stallKindE           obsKind;
    logic [`PC_W-1:0]    obsAddr;
    logic [`INSTR_W-1:0] obsInstr;

    int errorCount;
    int testErrors;
    int testCount;
    int testsFailed;

    hazardUnit u_hazardUnit (
        .clk         (clk),
        .arstN       (arstN),
        .imemData    (imemData),
        .imemAddr    (imemAddr),
        .decodeInstr (decodeInstr),
        .stallKind   (stallKind)
    );

    always #5 clk = ~clk;

    // Same cycle read, no wait states
    assign imemData = prog[imemAddr[9:2]];

    ////////////////////////////////////////////////////////////
    // Encoders and reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [`INSTR_W-1:0] encodeR(logic [4:0] rs, logic [4:0] rt,
                                                   logic [4:0] rd, logic [5:0] funct);
        return {6'd0, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [`INSTR_W-1:0] encodeI(opcodeE op, logic [4:0] rs,
                                                   logic [4:0] rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Packed as write flag over register index
    function automatic logic [5:0] refDest(logic [`INSTR_W-1:0] instr);
        opcodeE     op;
        logic [4:0] r;
        op = opcodeE'(instr[31:26]);
        if (op == opRtype) begin
            r = (instr[5:0] == `FUNCT_JR) ? 5'd0 : instr[15:11];
        end else if (op inside {opAddi, opAddiu, opSlti, opAndi, opOri, opLui, opLw}) begin
            r = instr[20:16];
        end else if (op == opJal) begin
            r = `LINK_REG;
        end else begin
            r = 5'd0;
        end
        // r0 is never a real write
        return {r != 5'd0, r};
    endfunction

    function automatic stallKindE predictStall(logic [`INSTR_W-1:0] instr);
        logic [4:0] rs;
        logic [4:0] rt;
        logic       hit;
        logic       branchOrJr;
        rs  = instr[25:21];
        rt  = instr[20:16];
        hit = (refExW && (refExRd == rs || refExRd == rt)) ||
              (refMemW && (refMemRd == rs || refMemRd == rt));
        // Opcodes 4 to 7 are the four branches
        branchOrJr = (instr[31:26] >= 6'd4 && instr[31:26] <= 6'd7) ||
                     (instr[31:26] == 6'd0 && instr[5:0] == `FUNCT_JR);
        if (!hit) begin
            return stallNone;
        end
        return branchOrJr ? stallControl : stallData;
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic checkStall(string name, stallKindE expVal, stallKindE actVal);
        if (actVal !== expVal) begin
            $display("FAILED t=%0t %s expected %s actual %s", $time, name,
                     expVal.name(), actVal.name());
            errorCount++;
        end
    endtask

    task automatic checkAddr(string name, logic [`PC_W-1:0] expVal, logic [`PC_W-1:0] actVal);
        if (actVal !== expVal) begin
            $display("FAILED t=%0t %s expected %h actual %h", $time, name, expVal, actVal);
            errorCount++;
        end
    endtask

    task automatic checkInstr(string name, logic [`INSTR_W-1:0] expVal,
                              logic [`INSTR_W-1:0] actVal);
        if (actVal !== expVal) begin
            $display("FAILED t=%0t %s expected %h actual %h", $time, name, expVal, actVal);
            errorCount++;
        end
    endtask

    task automatic checkCount(string name, int expVal, int actVal);
        if (actVal != expVal) begin
            $display("FAILED t=%0t %s expected %0d actual %0d", $time, name, expVal, actVal);
            errorCount++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Cycle stepping
    ////////////////////////////////////////////////////////////

    // Sample at the falling edge, model moves with the rising one
    task automatic stepCycle();
        stallKindE  expKind;
        logic [5:0] dest;
        @(negedge clk);
        expKind  = predictStall(refInstr);
        obsKind  = stallKind;
        obsAddr  = imemAddr;
        obsInstr = decodeInstr;
        checkStall("stallKind", expKind, obsKind);
        checkAddr("imemAddr", refPc, obsAddr);
        checkInstr("decodeInstr", refInstr, obsInstr);
        dest     = refDest(refInstr);
        refMemW  = refExW;
        refMemRd = refExRd;
        if (expKind == stallNone) begin
            refExW   = dest[5];
            refExRd  = dest[4:0];
            refInstr = prog[refPc[9:2]];
            refPc    = refPc + 32'd4;
        end else begin
            // Bubble into EX
            refExW  = 1'b0;
            refExRd = '0;
        end
        @(posedge clk);
    endtask

    task automatic resetDut();
        @(posedge clk);
        arstN <= 1'b0;
        repeat (16) @(posedge clk);
        arstN    <= 1'b1;
        refPc    = '0;
        refInstr = '0;
        refExW   = 1'b0;
        refExRd  = '0;
        refMemW  = 1'b0;
        refMemRd = '0;
    endtask

    // Store of r0 whose offset is its own word index
    task automatic clearProgram();
        for (int i = 0; i < 256; i++) begin
            prog[i] = encodeI(opSw, 5'd0, 5'd0, 16'(i));
        end
    endtask

    // Wait for the next stall, then time it
    task automatic measureStall(stallKindE expKind, int expLen);
        int               waited;
        int               len;
        logic [`PC_W-1:0] heldAddr;
        waited = 0;
        stepCycle();
        while (obsKind == stallNone && waited < waitLimit) begin
            stepCycle();
            waited++;
        end
        if (obsKind == stallNone) begin
            $display("t=%0t no stall began within %0d cycles", $time, waitLimit);
            errorCount++;
            return;
        end
        len      = 0;
        heldAddr = obsAddr;
        while (obsKind != stallNone && len < waitLimit) begin
            checkStall("stallKind", expKind, obsKind);
            checkAddr("imemAddr", heldAddr, obsAddr);
            len++;
            stepCycle();
        end
        if (obsKind != stallNone) begin
            $display("t=%0t stall did not end within %0d cycles", $time, waitLimit);
            errorCount++;
        end
        checkCount("stall length", expLen, len);
    endtask

    task automatic endTest(string name);
        testCount++;
        if (errorCount == testErrors) begin
            $display("%s: passed", name);
        end else begin
            testsFailed++;
            $display("%s: %0d errors", name, errorCount - testErrors);
        end
        testErrors = errorCount;
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic testReset();
        clearProgram();
        resetDut();
        stepCycle();
        checkAddr("imemAddr", '0, obsAddr);
        checkInstr("decodeInstr", '0, obsInstr);
        checkStall("stallKind", stallNone, obsKind);
    endtask

    task automatic testStream();
        logic [4:0] dest;
        logic [4:0] srcA;
        logic [4:0] srcB;
        clearProgram();
        // Sources in r1..r7, each destination from r8 up used once
        for (int i = 0; i < 16; i++) begin
            dest = 5'(8 + i);
            srcA = 5'(1 + $urandom_range(6));
            srcB = 5'(1 + $urandom_range(6));
            case ($urandom_range(3))
                0: prog[i] = encodeR(srcA, srcB, dest, 6'h20);
                1: prog[i] = encodeI(opAddi, srcA, dest, 16'($urandom));
                2: prog[i] = encodeI(opOri, srcA, dest, 16'($urandom));
                default: prog[i] = encodeI(opLw, srcA, dest, 16'($urandom));
            endcase
        end
        resetDut();
        for (int cyc = 0; cyc < 20; cyc++) begin
            stepCycle();
            checkStall("stallKind", stallNone, obsKind);
            checkAddr("imemAddr", 32'(cyc * 4), obsAddr);
            checkInstr("decodeInstr", (cyc == 0) ? 32'd0 : prog[8'(cyc - 1)], obsInstr);
        end
    endtask

    task automatic testDataStall();
        clearProgram();
        // r3 consumed right away
        prog[0] = encodeR(5'd1, 5'd2, 5'd3, 6'h20);
        prog[1] = encodeR(5'd3, 5'd1, 5'd4, 6'h20);
        // r10 consumed with one instruction between
        prog[2] = encodeR(5'd1, 5'd2, 5'd10, 6'h20);
        prog[3] = encodeR(5'd1, 5'd2, 5'd11, 6'h20);
        prog[4] = encodeR(5'd10, 5'd1, 5'd12, 6'h20);
        resetDut();
        measureStall(stallData, 2);
        measureStall(stallData, 1);
    endtask

    task automatic testControlStall();
        clearProgram();
        // Load into r5, branch on it next
        prog[0] = encodeI(opLw, 5'd1, 5'd5, 16'h0010);
        prog[1] = encodeI(opBeq, 5'd5, 5'd2, 16'h0004);
        // r6 target for JR two slots later
        prog[2] = encodeI(opAddi, 5'd1, 5'd6, 16'h0001);
        prog[3] = encodeR(5'd1, 5'd2, 5'd7, 6'h20);
        prog[4] = encodeR(5'd6, 5'd0, 5'd0, `FUNCT_JR);
        resetDut();
        measureStall(stallControl, 2);
        measureStall(stallControl, 1);
    endtask

    task automatic testNoFalseStall();
        clearProgram();
        // Write to r0, then read r0
        prog[0] = encodeI(opAddi, 5'd1, 5'd0, 16'h0005);
        prog[1] = encodeR(5'd0, 5'd0, 5'd2, 6'h20);
        // Non writers, each followed by a reader of their register fields
        // JR carries a stray rd field
        prog[2] = encodeR(5'd5, 5'd0, 5'd7, `FUNCT_JR);
        prog[3] = encodeR(5'd5, 5'd7, 5'd8, 6'h20);
        prog[4] = encodeI(opSw, 5'd5, 5'd6, 16'h0000);
        prog[5] = encodeR(5'd5, 5'd6, 5'd9, 6'h20);
        prog[6] = encodeI(opBeq, 5'd13, 5'd14, 16'h0008);
        prog[7] = encodeR(5'd13, 5'd14, 5'd15, 6'h20);
        resetDut();
        for (int cyc = 0; cyc < 12; cyc++) begin
            stepCycle();
            checkStall("stallKind", stallNone, obsKind);
        end
    endtask

    initial begin
        void'($urandom(32'h19b6_b7f0));
        clk         = 1'b0;
        arstN       = 1'b0;
        errorCount  = 0;
        testErrors  = 0;
        testCount   = 0;
        testsFailed = 0;
        clearProgram();
        testReset();
        endTest("reset values");
        testStream();
        endTest("independent stream");
        testDataStall();
        endTest("data stalls");
        testControlStall();
        endTest("control stalls");
        testNoFalseStall();
        endTest("no false stalls");
        $display("%0d tests, %0d with errors, %0d failed checks",
                 testCount, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+hw
hw/pipelinePkg.sv
hw/pipeWriterIf.sv
hw/fetchUnit.sv
hw/destDecode.sv
hw/writerTrack.sv
hw/hazardDetect.sv
hw/hazardUnit.sv
tests/tb_hazardUnit.sv

// File: run.sh
#!/bin/sh
# Compile and run the hazard unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module tb_hazardUnit -o simHazardUnit

out=$(./obj_dir/simHazardUnit)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
